//--- logic/aluPkg.sv
package aluPkg;

    ////////////////////////////////////////////////////////////
    // Basic widths and operand codes
    ////////////////////////////////////////////////////////////

    // One data byte, as held in A, X, Y, P and on every operand bus
    typedef logic [7:0] byteT;

    // Operation code, read differently by each functional unit
    typedef logic [1:0] opT;

    // Two bit operand select for the left and right operand buses
    typedef logic [1:0] opSelT;

    // Functional unit select, zero is the NOP so an all-zero command does nothing
    typedef enum logic [2:0] {
        fuNop   = 3'd0,
        fuXfr   = 3'd1,
        fuLogic = 3'd2,
        fuShift = 3'd3,
        fuAdd   = 3'd4,
        fuIdc   = 3'd5
    } fuSelT;

    // Carry into the shifter and the adder
    typedef enum logic [1:0] {
        ciFlag = 2'd0,
        ciMsb  = 2'd1,
        ciZero = 2'd2,
        ciOne  = 2'd3
    } carrySelT;

    // Destination register, and also the source of a transfer
    // Only a transfer may name M, a write to M is meaningless here
    typedef enum logic [2:0] {
        regNone = 3'd0,
        regA    = 3'd1,
        regX    = 3'd2,
        regY    = 3'd3,
        regP    = 3'd4,
        regM    = 3'd5
    } regSelT;

    // Which flags in P the result touches
    typedef enum logic [2:0] {
        updNone = 3'd0,
        updZ    = 3'd1,
        updNvz  = 3'd2,
        updNz   = 3'd3,
        updNzc  = 3'd4,
        updNvzc = 3'd5
    } flagUpdT;

    // Branch condition tested into the registered condition code
    typedef enum logic [3:0] {
        ccTrue = 4'd0,
        ccCc   = 4'd1,
        ccCs   = 4'd2,
        ccNe   = 4'd3,
        ccEq   = 4'd4,
        ccVc   = 4'd5,
        ccVs   = 4'd6,
        ccPl   = 4'd7,
        ccMi   = 4'd8
    } ccTestT;

    ////////////////////////////////////////////////////////////
    // Command and pipeline structs
    ////////////////////////////////////////////////////////////

    // One command word as issued by the sequencer
    typedef struct packed {
        fuSelT    fuSel;
        opT       op;
        opSelT    qSel;
        opSelT    rSel;
        carrySelT cSel;
        regSelT   wSel;
        regSelT   oSel;
        flagUpdT  flagUpd;
        ccTestT   ccTest;
        byteT     k;
        byteT     m;
    } aluCmdT;

    // Operands and control held between the operand and the execute stage
    typedef struct packed {
        logic    valid;
        fuSelT   fuSel;
        opT      op;
        byteT    lOperand;
        byteT    qOperand;
        byteT    rOperand;
        logic    carryIn;
        byteT    xfrOperand;
        regSelT  wSel;
        flagUpdT flagUpd;
        ccTestT  ccTest;
        // Bits 7 and 6 of M, which BIT copies into N and V
        logic [1:0] mTop;
    } execOpT;

    // Output of the execute stage
    typedef struct packed {
        byteT result;
        logic carryOut;
        logic overflow;
        logic logicZero;
    } execResT;

    // The architectural registers
    typedef struct packed {
        byteT a;
        byteT x;
        byteT y;
        byteT p;
    } archRegsT;

    ////////////////////////////////////////////////////////////
    // Status word layout {N, V, 1, B, D, I, Z, C}
    ////////////////////////////////////////////////////////////

    localparam int flagN   = 7;
    localparam int flagV   = 6;
    localparam int flagOne = 5;
    localparam int flagB   = 4;
    localparam int flagD   = 3;
    localparam int flagI   = 2;
    localparam int flagZ   = 1;
    localparam int flagC   = 0;

    // Only the unused bit is set out of reset
    localparam byteT pResetValue = 8'h20;

endpackage

//--- logic/operandStage.sv
`timescale 1ns/10ps

module operandStage import aluPkg::*; (
    input  logic     Clk,
    input  logic     rstN,
    input  logic     rdy,
    input  logic     cmdEn,
    input  aluCmdT   cmd,
    input  archRegsT regsNext,
    output execOpT   execOp
);

    // Operand stage output before the pipeline register
    execOpT nextOp;

    ////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////

    // All register reads come from regsNext, so a command issued right
    // behind one that writes A, X, Y or P already sees the new value
    always_comb
    begin
        nextOp = '0;

        nextOp.valid   = cmdEn;
        nextOp.fuSel   = cmd.fuSel;
        nextOp.op      = cmd.op;
        nextOp.wSel    = cmd.wSel;
        nextOp.flagUpd = cmd.flagUpd;
        nextOp.ccTest  = cmd.ccTest;
        nextOp.mTop    = cmd.m[7:6];

        // Left operand of the logic unit, picks among M, A, K and P
        case (cmd.qSel)
            2'd0:    nextOp.lOperand = cmd.m;
            2'd1:    nextOp.lOperand = regsNext.a;
            2'd2:    nextOp.lOperand = cmd.k;
            default: nextOp.lOperand = regsNext.p;
        endcase

        // The same select drives the shifter and adder operand, but over M, A, X, Y
        case (cmd.qSel)
            2'd0:    nextOp.qOperand = cmd.m;
            2'd1:    nextOp.qOperand = regsNext.a;
            2'd2:    nextOp.qOperand = regsNext.x;
            default: nextOp.qOperand = regsNext.y;
        endcase

        // Right operand, shared by the logic unit and the adder
        // K gives INC/DEC by any step and the RMB/SMB/SEC/CLC masks
        case (cmd.rSel)
            2'd0:    nextOp.rOperand = cmd.m;
            2'd1:    nextOp.rOperand = regsNext.a;
            2'd2:    nextOp.rOperand = cmd.k;
            default: nextOp.rOperand = regsNext.p;
        endcase

        // Carry in, bit 7 of the shift operand would give an arithmetic shift
        case (cmd.cSel)
            ciFlag:  nextOp.carryIn = regsNext.p[flagC];
            ciMsb:   nextOp.carryIn = nextOp.qOperand[7];
            ciZero:  nextOp.carryIn = 1'b0;
            default: nextOp.carryIn = 1'b1;
        endcase

        // Transfer source, regNone puts zero on the bus for STZ
        case (cmd.oSel)
            regA:    nextOp.xfrOperand = regsNext.a;
            regX:    nextOp.xfrOperand = regsNext.x;
            regY:    nextOp.xfrOperand = regsNext.y;
            regP:    nextOp.xfrOperand = regsNext.p;
            regM:    nextOp.xfrOperand = cmd.m;
            default: nextOp.xfrOperand = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Pipeline register
    ////////////////////////////////////////////////////////////

    // A stall holds the register, and with cmdEn low a bubble enters
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
            execOp <= '0;
        else if (rdy)
            execOp <= nextOp;
    end

    // M is only a transfer source and can never be written back
    noMemDest: assert property (@(posedge Clk) disable iff (!rstN)
        (cmdEn && rdy) |-> (cmd.wSel != regM))
        else $error("operandStage accepted a command with destination M");

endmodule

//--- logic/adderUnit.sv
`timescale 1ns/10ps

module adderUnit import aluPkg::*; (
    input  byteT q,
    input  byteT r,
    input  logic carryIn,
    input  logic subtract,
    output byteT sum,
    output logic carryOut,
    output logic overflow
);

    // Right addend after the optional complement
    byteT rEff;

    // Nine bit sum, the top bit is the carry out
    logic [8:0] fullSum;

    ////////////////////////////////////////////////////////////
    // Binary adder
    ////////////////////////////////////////////////////////////

    // Subtraction is q plus the ones complement of r plus carry in
    // SBC keeps the carry from C, CMP forces it to one
    assign rEff = subtract ? ~r : r;

    assign fullSum = {1'b0, q} + {1'b0, rEff} + {8'd0, carryIn};

    assign sum      = fullSum[7:0];
    assign carryOut = fullSum[8];

    // Two's complement overflow
    // The addends agree in sign but the sum does not
    assign overflow = (q[7] == rEff[7]) && (fullSum[7] != q[7]);

endmodule

//--- logic/executeStage.sv
`timescale 1ns/10ps

module executeStage import aluPkg::*; (
    input  execOpT  execOp,
    output execResT execRes
);

    // Logic unit result
    byteT logicOut;

    // Shift unit result and the bit shifted out
    byteT shiftOut;
    logic shiftCarry;

    // Adder outputs
    byteT addSum;
    logic addCarry;
    logic addOverflow;

    ////////////////////////////////////////////////////////////
    // Logic unit
    ////////////////////////////////////////////////////////////

    // AND-NOT clears the left operand bits out of the right one
    // This covers TRB, RMB and the flag clear instructions
    always_comb
    begin
        case (execOp.op)
            2'd0:    logicOut = execOp.rOperand & ~execOp.lOperand;
            2'd1:    logicOut = execOp.lOperand & execOp.rOperand;
            2'd2:    logicOut = execOp.lOperand | execOp.rOperand;
            default: logicOut = execOp.lOperand ^ execOp.rOperand;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Shift unit
    ////////////////////////////////////////////////////////////

    // ASL and ROL differ only in the carry in, as do LSR and ROR
    always_comb
    begin
        if (execOp.op[0])
        begin
            shiftOut   = {execOp.carryIn, execOp.qOperand[7:1]};
            shiftCarry = execOp.qOperand[0];
        end
        else
        begin
            shiftOut   = {execOp.qOperand[6:0], execOp.carryIn};
            shiftCarry = execOp.qOperand[7];
        end
    end

    ////////////////////////////////////////////////////////////
    // Adder for ADC, SBC, INC, DEC and CMP
    ////////////////////////////////////////////////////////////

    adderUnit u_adderUnit (
        .q        (execOp.qOperand),
        .r        (execOp.rOperand),
        .carryIn  (execOp.carryIn),
        .subtract (execOp.op[0]),
        .sum      (addSum),
        .carryOut (addCarry),
        .overflow (addOverflow)
    );

    ////////////////////////////////////////////////////////////
    // Result multiplexer
    ////////////////////////////////////////////////////////////

    // Only the shifter and the adder drive a carry out, so an NZC update
    // after a transfer or logic op clears C
    always_comb
    begin
        execRes = '0;

        // BIT, TRB, TSB and BBR/BBS all test A AND M or K AND M
        execRes.logicZero = ~|(execOp.lOperand & execOp.rOperand);

        case (execOp.fuSel)
            fuXfr:   execRes.result = execOp.xfrOperand;
            fuLogic: execRes.result = logicOut;
            fuShift:
            begin
                execRes.result   = shiftOut;
                execRes.carryOut = shiftCarry;
            end
            fuAdd, fuIdc:
            begin
                execRes.result   = addSum;
                execRes.carryOut = addCarry;
                execRes.overflow = addOverflow;
            end
            default: execRes.result = '0;
        endcase
    end

endmodule

//--- logic/registerFile.sv
`timescale 1ns/10ps

module registerFile import aluPkg::*; (
    input  logic     Clk,
    input  logic     rstN,
    input  logic     rdy,
    input  execOpT   execOp,
    input  execResT  execRes,
    output archRegsT regs,
    output archRegsT regsNext,
    output byteT     dataOut,
    output logic     resultValid,
    output logic     ccOut
);

    // Register values with the stage-1 item applied
    archRegsT updRegs;

    // Zero test for the branch, and the condition it gives
    logic zTest;
    logic ccNext;

    ////////////////////////////////////////////////////////////
    // Writeback and flag update
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        updRegs = regs;

        case (execOp.wSel)
            regA: updRegs.a = execRes.result;
            regX: updRegs.x = execRes.result;
            regY: updRegs.y = execRes.result;
            regP:
            begin
                // PLP, REP/SEP and the set/clear ops load all of P
                updRegs.p          = execRes.result;
                updRegs.p[flagOne] = 1'b1;
            end
            default: ;
        endcase

        // A full P load already carries its own flags
        if (execOp.wSel != regP)
        begin
            case (execOp.flagUpd)
                updZ: updRegs.p[flagZ] = execRes.logicZero;
                updNvz:
                begin
                    // BIT takes N and V straight from memory
                    updRegs.p[flagN] = execOp.mTop[1];
                    updRegs.p[flagV] = execOp.mTop[0];
                    updRegs.p[flagZ] = execRes.logicZero;
                end
                updNz, updNzc, updNvzc:
                begin
                    updRegs.p[flagN] = execRes.result[7];
                    updRegs.p[flagZ] = ~|execRes.result;
                    if (execOp.flagUpd != updNz)
                        updRegs.p[flagC] = execRes.carryOut;
                    if (execOp.flagUpd == updNvzc)
                        updRegs.p[flagV] = execRes.overflow;
                end
                default: ;
            endcase
        end
    end

    // Bypass to the operand stage, a bubble leaves the registers alone
    assign regsNext = execOp.valid ? updRegs : regs;

    ////////////////////////////////////////////////////////////
    // Condition code
    ////////////////////////////////////////////////////////////

    // BBR and BBS branch on the mask test rather than the Z flag
    assign zTest = (execOp.fuSel == fuLogic) ? execRes.logicZero : updRegs.p[flagZ];

    always_comb
    begin
        case (execOp.ccTest)
            ccCc:    ccNext = ~updRegs.p[flagC];
            ccCs:    ccNext = updRegs.p[flagC];
            ccNe:    ccNext = ~zTest;
            ccEq:    ccNext = zTest;
            ccVc:    ccNext = ~updRegs.p[flagV];
            ccVs:    ccNext = updRegs.p[flagV];
            ccPl:    ccNext = ~updRegs.p[flagN];
            ccMi:    ccNext = updRegs.p[flagN];
            default: ccNext = 1'b1;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    // Nothing moves on a stall edge and resultValid drops
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            regs        <= '{a: '0, x: '0, y: '0, p: pResetValue};
            resultValid <= 1'b0;
            ccOut       <= 1'b1;
        end
        else if (rdy)
        begin
            regs        <= regsNext;
            resultValid <= execOp.valid;
            if (execOp.valid)
                ccOut <= ccNext;
        end
        else
            resultValid <= 1'b0;
    end

    // Store data or result byte, qualified by resultValid
    always_ff @(posedge Clk)
    begin
        if (rdy && execOp.valid)
            dataOut <= execRes.result;
    end

    // Neither reset, a P load nor any flag update may clear the unused bit
    pBitOneSet: assert property (@(posedge Clk) disable iff (!rstN) regs.p[flagOne])
        else $error("registerFile lost P bit 5");

endmodule

//--- logic/aluTop.sv
`timescale 1ns/10ps

module aluTop import aluPkg::*; (
    input  logic     Clk,
    input  logic     rstN,
    input  logic     cmdEn,
    input  aluCmdT   cmd,
    input  logic     rdy,
    output byteT     dataOut,
    output logic     resultValid,
    output logic     ccOut,
    output archRegsT regs
);

    ////////////////////////////////////////////////////////////
    // Pipeline wiring
    ////////////////////////////////////////////////////////////

    // Registered stage-1 item
    execOpT   execOp;
    execResT  execRes;

    // Registers as they stand after the coming writeback
    archRegsT regsNext;

    operandStage u_operandStage (
        .Clk      (Clk),
        .rstN     (rstN),
        .rdy      (rdy),
        .cmdEn    (cmdEn),
        .cmd      (cmd),
        .regsNext (regsNext),
        .execOp   (execOp)
    );

    executeStage u_executeStage (
        .execOp  (execOp),
        .execRes (execRes)
    );

    registerFile u_registerFile (
        .Clk         (Clk),
        .rstN        (rstN),
        .rdy         (rdy),
        .execOp      (execOp),
        .execRes     (execRes),
        .regs        (regs),
        .regsNext    (regsNext),
        .dataOut     (dataOut),
        .resultValid (resultValid),
        .ccOut       (ccOut)
    );

endmodule

//--- tb/aluModel.svh
`ifndef aluModelSvh
`define aluModelSvh

////////////////////////////////////////////////////////////
// Reference model of the execution unit
////////////////////////////////////////////////////////////

// What one accepted command should leave behind when it completes
typedef struct packed {
    byteT     data;
    logic     cc;
    archRegsT regs;
} expectT;

// Two's complement value of a byte
function automatic int signedValue(input byteT b);
    return b[7] ? int'(b) - 256 : int'(b);
endfunction

// Left operand of the logic unit picks among M, A, K and P
function automatic byteT leftLogicOperand(input aluCmdT c, input archRegsT r);
    case (c.qSel)
        2'd0:    return c.m;
        2'd1:    return r.a;
        2'd2:    return c.k;
        default: return r.p;
    endcase
endfunction

// The shifter and adder read M, A, X or Y with the same select
function automatic byteT shiftAddOperand(input aluCmdT c, input archRegsT r);
    case (c.qSel)
        2'd0:    return c.m;
        2'd1:    return r.a;
        2'd2:    return r.x;
        default: return r.y;
    endcase
endfunction

function automatic byteT rightOperand(input aluCmdT c, input archRegsT r);
    case (c.rSel)
        2'd0:    return c.m;
        2'd1:    return r.a;
        2'd2:    return c.k;
        default: return r.p;
    endcase
endfunction

// Zero is the source for regNone
function automatic byteT transferSource(input aluCmdT c, input archRegsT r);
    case (c.oSel)
        regA:    return r.a;
        regX:    return r.x;
        regY:    return r.y;
        regP:    return r.p;
        regM:    return c.m;
        default: return 8'h00;
    endcase
endfunction

// Runs one command on the model registers in program order
// The operands come from the registers as left by the previous command
function automatic expectT applyCommand(input aluCmdT c, inout archRegsT r);
    byteT   lOp;
    byteT   qOp;
    byteT   rOp;
    byteT   addend;
    byteT   res;
    logic   ci;
    logic   co;
    logic   ov;
    logic   lz;
    logic   zt;
    logic   cc;
    int     uSum;
    int     sSum;
    expectT e;

    lOp = leftLogicOperand(c, r);
    qOp = shiftAddOperand(c, r);
    rOp = rightOperand(c, r);
    case (c.cSel)
        ciFlag:  ci = r.p[flagC];
        ciMsb:   ci = qOp[7];
        ciZero:  ci = 1'b0;
        default: ci = 1'b1;
    endcase

    res = 8'h00;
    co  = 1'b0;
    ov  = 1'b0;
    lz  = ((lOp & rOp) == 8'h00);

    case (c.fuSel)
        fuXfr:   res = transferSource(c, r);
        fuLogic:
        begin
            case (c.op)
                2'd0:    res = rOp & ~lOp;
                2'd1:    res = lOp & rOp;
                2'd2:    res = lOp | rOp;
                default: res = lOp ^ rOp;
            endcase
        end
        fuShift:
        begin
            if (c.op[0])
            begin
                res = {ci, qOp[7:1]};
                co  = qOp[0];
            end
            else
            begin
                res = {qOp[6:0], ci};
                co  = qOp[7];
            end
        end
        fuAdd, fuIdc:
        begin
            // Overflow is judged on the signed sum falling out of range
            addend = c.op[0] ? ~rOp : rOp;
            uSum   = int'(qOp) + int'(addend) + int'(ci);
            res    = uSum[7:0];
            co     = (uSum > 255);
            sSum   = signedValue(qOp) + signedValue(addend) + int'(ci);
            ov     = (sSum > 127) || (sSum < -128);
        end
        default: res = 8'h00;
    endcase

    case (c.wSel)
        regA: r.a = res;
        regX: r.x = res;
        regY: r.y = res;
        regP: r.p = res | 8'h20;
        default: ;
    endcase

    // Flags only move when P itself was not loaded
    if (c.wSel != regP)
    begin
        case (c.flagUpd)
            updZ: r.p[flagZ] = lz;
            updNvz:
            begin
                r.p[flagN] = c.m[7];
                r.p[flagV] = c.m[6];
                r.p[flagZ] = lz;
            end
            updNz, updNzc, updNvzc:
            begin
                r.p[flagN] = res[7];
                r.p[flagZ] = (res == 8'h00);
                if (c.flagUpd != updNz)
                    r.p[flagC] = co;
                if (c.flagUpd == updNvzc)
                    r.p[flagV] = ov;
            end
            default: ;
        endcase
    end

    // Bit-test branches look at the mask test of a logic command
    zt = (c.fuSel == fuLogic) ? lz : r.p[flagZ];
    case (c.ccTest)
        ccCc:    cc = !r.p[flagC];
        ccCs:    cc = r.p[flagC];
        ccNe:    cc = !zt;
        ccEq:    cc = zt;
        ccVc:    cc = !r.p[flagV];
        ccVs:    cc = r.p[flagV];
        ccPl:    cc = !r.p[flagN];
        ccMi:    cc = r.p[flagN];
        default: cc = 1'b1;
    endcase

    e.data = res;
    e.cc   = cc;
    e.regs = r;
    return e;
endfunction

`endif

//--- tb/aluTb.sv
`timescale 1ns/10ps

module aluTb import aluPkg::*; ();

    logic     Clk;
    logic     rstN;
    logic     cmdEn;
    aluCmdT   cmd;
    logic     rdy;
    byteT     dataOut;
    logic     resultValid;
    logic     ccOut;
    archRegsT regs;

    `include "aluModel.svh"

    // Model registers, and the results still owed by the DUT in order
    archRegsT mdlRegs;
    expectT   expQ[$];

    // Registers seen at the previous sample, for the stall check
    archRegsT lastRegs;
    int       accepted;
    int       stallAge;

    aluTop u_aluTop (
        .Clk         (Clk),
        .rstN        (rstN),
        .cmdEn       (cmdEn),
        .cmd         (cmd),
        .rdy         (rdy),
        .dataOut     (dataOut),
        .resultValid (resultValid),
        .ccOut       (ccOut),
        .regs        (regs)
    );

    initial
    begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    ////////////////////////////////////////////////////////////
    // Failure handling and the compare
    ////////////////////////////////////////////////////////////

    task automatic abortSimulation();
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first failed check");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[ERROR] %s expected %h got %h", name, expected, actual);
            abortSimulation();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Any legal command, never a write to M
    function automatic aluCmdT randomCommand();
        aluCmdT c;

        c.fuSel   = fuSelT'($urandom_range(5, 0));
        c.op      = opT'($urandom_range(3, 0));
        c.qSel    = opSelT'($urandom_range(3, 0));
        c.rSel    = opSelT'($urandom_range(3, 0));
        c.cSel    = carrySelT'($urandom_range(3, 0));
        c.wSel    = regSelT'($urandom_range(4, 0));
        c.oSel    = regSelT'($urandom_range(5, 0));
        c.flagUpd = flagUpdT'($urandom_range(5, 0));
        c.ccTest  = ccTestT'($urandom_range(8, 0));
        c.k       = byteT'($urandom);
        c.m       = byteT'($urandom);
        // Half of the masks are single bits as RMB, SMB and BBR/BBS use them
        if ($urandom_range(1, 0) == 1)
            c.k = 8'h01 << $urandom_range(7, 0);
        return c;
    endfunction

    // One clock: sample what the DUT takes at the edge, drive the next
    // inputs, then check the outputs half a cycle later
    task automatic stepCycle(input logic holdHigh, input logic issue);
        logic   sawRdy;
        logic   sawAccept;
        aluCmdT sawCmd;
        int     pendingBefore;
        expectT expItem;

        @(posedge Clk);
        sawRdy        = rdy;
        sawAccept     = cmdEn && rdy;
        sawCmd        = cmd;
        pendingBefore = expQ.size();
        if (sawAccept)
        begin
            expItem = applyCommand(sawCmd, mdlRegs);
            expQ.push_back(expItem);
            accepted++;
        end

        if (holdHigh)
        begin
            cmd   <= randomCommand();
            cmdEn <= 1'b1;
            rdy   <= 1'b1;
        end
        else
        begin
            // A command refused by a stall is held until it gets in
            if (sawRdy || !cmdEn)
            begin
                cmd   <= randomCommand();
                cmdEn <= issue && ($urandom_range(3, 0) != 0);
            end
            rdy <= ($urandom_range(3, 0) != 0);
        end

        @(negedge Clk);
        if (sawRdy && pendingBefore > 0)
        begin
            // The older item completes at the first rdy edge after it got in
            checkValue("resultValid", 32'd1, resultValid);
            expItem = expQ.pop_front();
            checkValue("dataOut", expItem.data, dataOut);
            checkValue("ccOut", expItem.cc, ccOut);
            checkValue("regs", expItem.regs, regs);
            stallAge = 0;
        end
        else
        begin
            checkValue("resultValid", 32'd0, resultValid);
            checkValue("regs", lastRegs, regs);
            if (expQ.size() > 0)
                stallAge++;
            if (stallAge > 100)
            begin
                $display("Timed out waiting for resultValid");
                abortSimulation();
            end
        end
        lastRegs = regs;
    endtask

    task automatic issueCommands(input int count, input logic holdHigh);
        int target;
        int waitCycles;

        repeat (count)
        begin
            target     = accepted + 1;
            waitCycles = 0;
            while (accepted < target)
            begin
                if (waitCycles == 200)
                begin
                    $display("Timed out waiting for a command to be accepted");
                    abortSimulation();
                end
                stepCycle(holdHigh, 1'b1);
                waitCycles++;
            end
        end
    endtask

    // Lets the last results come out with no new commands behind them
    task automatic drainPipeline();
        int waitCycles;

        waitCycles = 0;
        while (expQ.size() > 0)
        begin
            if (waitCycles == 200)
            begin
                $display("Timed out waiting for resultValid while draining");
                abortSimulation();
            end
            stepCycle(1'b0, 1'b0);
            waitCycles++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        rstN     = 1'b0;
        cmdEn    = 1'b0;
        rdy      = 1'b0;
        cmd      = '0;
        accepted = 0;
        stallAge = 0;
        void'($urandom(32'haec5_316b));
        mdlRegs = '{a: 8'h00, x: 8'h00, y: 8'h00, p: pResetValue};

        repeat (3) @(posedge Clk);
        rstN <= 1'b1;

        // State straight out of reset
        @(negedge Clk);
        checkValue("regs", mdlRegs, regs);
        checkValue("ccOut", 32'd1, ccOut);
        checkValue("resultValid", 32'd0, resultValid);
        lastRegs = regs;

        // Back to back with rdy high, every command reads the one before
        issueCommands(300, 1'b1);

        // Random cmdEn and rdy stalls
        issueCommands(1700, 1'b0);
        drainPipeline();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- tb.f
+incdir+tb
logic/aluPkg.sv
logic/operandStage.sv
logic/adderUnit.sv
logic/executeStage.sv
logic/registerFile.sv
logic/aluTop.sv
tb/aluTb.sv
